// File: Bender.yml
package:
  name: rv_mem_wb

sources:
  - include_dirs:
      - src
    files:
      - src/rv_pkg.sv
      - src/rv_memory.sv
      - src/rv_data_ram.sv
      - src/rv_write.sv
      - src/rv_regfile.sv
      - src/rv_mem_wb.sv

  - target: test
    include_dirs:
      - src
    files:
      - test/tb_clock.sv
      - test/tb_rv_mem_wb.sv

// File: rv_mem_wb.f
+incdir+src
src/rv_pkg.sv
src/rv_memory.sv
src/rv_data_ram.sv
src/rv_write.sv
src/rv_regfile.sv
src/rv_mem_wb.sv
test/tb_clock.sv
test/tb_rv_mem_wb.sv

// File: src/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data word width
`define RV_XLEN         32

// register file address width
`define RV_REG_AW       5

// data RAM depth in words
`define RV_RAM_WORDS    256
`define RV_RAM_AW       $clog2(`RV_RAM_WORDS)

`endif

// File: src/rv_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_data_ram
(
    input  wire                   i_clk,
    input  wire rv_pkg::ram_req_t i_req,
    output logic [`RV_XLEN-1:0]   o_rdata
);

    logic [`RV_XLEN-1:0] mem [`RV_RAM_WORDS];

    always_ff @(posedge i_clk)
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (i_req.write && i_req.be[i])
            begin
                mem[i_req.addr][i*8 +: 8] <= i_req.wdata[i*8 +: 8];
            end
        end
        o_rdata <= mem[i_req.addr];     // old word on a same-cycle write
    end

    // lane enables come only with a write
    a_be_with_write: assert property (@(posedge i_clk)
        (i_req.be != 4'b0000) |-> i_req.write);

endmodule

`default_nettype wire

// File: src/rv_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_mem_wb
(
    input  wire                   i_clk,
    input  wire                   i_reset,
    input  wire                   i_flush,
    input  wire rv_pkg::ex_mem_t  i_op,
    input  wire [`RV_REG_AW-1:0]  i_rs_addr,
    output rv_pkg::wb_t           o_wb,
    output logic [`RV_XLEN-1:0]   o_rs_data
);

    import rv_pkg::*;

    ram_req_t            ram_req;
    mem_wb_t             wb_op;
    logic [`RV_XLEN-1:0] ram_rdata;     // registered read word

    rv_memory u_memory
    (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_flush    (i_flush),
        .i_op       (i_op),
        .o_ram_req  (ram_req),
        .o_wb_op    (wb_op)
    );

    rv_data_ram u_data_ram
    (
        .i_clk      (i_clk),
        .i_req      (ram_req),
        .o_rdata    (ram_rdata)
    );

    rv_write u_write
    (
        .i_clk      (i_clk),
        .i_flush    (i_flush),
        .i_op       (wb_op),
        .i_data     (ram_rdata),
        .o_wb       (o_wb)
    );

    rv_regfile u_regfile
    (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_wb       (o_wb),
        .i_rs_addr  (i_rs_addr),
        .o_rs_data  (o_rs_data)
    );

endmodule

`default_nettype wire

// File: src/rv_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_memory
(
    input  wire                   i_clk,
    input  wire                   i_reset,
    input  wire                   i_flush,
    input  wire rv_pkg::ex_mem_t  i_op,
    output rv_pkg::ram_req_t      o_ram_req,
    output rv_pkg::mem_wb_t       o_wb_op
);

    import rv_pkg::*;

    ex_mem_t             op_q;
    logic [`RV_XLEN-1:0] lane_data;
    logic [3:0]          lanes;
    logic                aligned;
    logic                write;

    // payload captured every edge and flags cleared on reset or flush
    always_ff @(posedge i_clk)
    begin
        op_q <= i_op;
        if (i_reset || i_flush)
        begin
            op_q.res_src   <= '0;
            op_q.mem_write <= 1'b0;
            op_q.reg_write <= 1'b0;
        end
    end

    always_comb
    begin
        case (op_q.funct3)
        LS_B:
        begin
            lane_data = {4{op_q.store_data[7:0]}};
            lanes     = 4'b0001 << op_q.alu_result[1:0];
            aligned   = 1'b1;
        end
        LS_H:
        begin
            lane_data = {2{op_q.store_data[15:0]}};
            lanes     = op_q.alu_result[1] ? 4'b1100 : 4'b0011;
            aligned   = !op_q.alu_result[0];
        end
        LS_W:
        begin
            lane_data = op_q.store_data;
            lanes     = 4'b1111;
            aligned   = op_q.alu_result[1:0] == 2'b00;
        end
        default:
        begin
            lane_data = op_q.store_data;    // no store of this width
            lanes     = 4'b0000;
            aligned   = 1'b1;
        end
        endcase
    end

    // a flush at this edge also kills the RAM write
    assign write = op_q.mem_write && !i_flush;

    always_comb
    begin
        o_ram_req.addr  = op_q.alu_result[2 +: `RV_RAM_AW];
        o_ram_req.wdata = lane_data;
        o_ram_req.be    = write ? lanes : 4'b0000;
        o_ram_req.write = write;
    end

    assign o_wb_op = '{
        alu_result: op_q.alu_result,
        funct3:     op_q.funct3,
        res_src:    op_q.res_src,
        reg_write:  op_q.reg_write,
        rd:         op_q.rd
    };

    a_store_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
        op_q.mem_write |-> aligned);

    a_res_src_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
        $onehot0(op_q.res_src));

endmodule

`default_nettype wire

// File: src/rv_pkg.sv
`default_nettype none

`include "rv_consts.svh"

package rv_pkg;

    // one-hot result source
    typedef struct packed {
        logic alu;
        logic memory;
        logic pc_next;
    } res_src_t;

    // funct3 encodings for load/store width
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_BU = 3'b100,
        LS_HU = 3'b101
    } ls_width_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   alu_result;     // also load/store address
        logic [`RV_XLEN-1:0]   store_data;
        ls_width_t             funct3;
        res_src_t              res_src;
        logic                  mem_write;
        logic                  reg_write;
        logic [`RV_REG_AW-1:0] rd;
    } ex_mem_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   alu_result;
        ls_width_t             funct3;
        res_src_t              res_src;
        logic                  reg_write;
        logic [`RV_REG_AW-1:0] rd;
    } mem_wb_t;

    typedef struct packed {
        logic [`RV_RAM_AW-1:0] addr;           // word address
        logic [`RV_XLEN-1:0]   wdata;
        logic [3:0]            be;
        logic                  write;
    } ram_req_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   data;
        logic [`RV_REG_AW-1:0] rd;
        logic                  write;
    } wb_t;

endpackage

`default_nettype wire

// File: src/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_regfile
(
    input  wire                  i_clk,
    input  wire                  i_reset,
    input  wire rv_pkg::wb_t     i_wb,
    input  wire [`RV_REG_AW-1:0] i_rs_addr,
    output logic [`RV_XLEN-1:0]  o_rs_data
);

    logic [`RV_XLEN-1:0] regs [1 << `RV_REG_AW];

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < (1 << `RV_REG_AW); i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_wb.write && (i_wb.rd != '0))    // x0 never written
        begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // async read without bypass of a same-cycle write
    always_comb
    begin
        if (i_rs_addr == '0)
        begin
            o_rs_data = '0;
        end
        else
        begin
            o_rs_data = regs[i_rs_addr];
        end
    end

endmodule

`default_nettype wire

// File: src/rv_write.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_write
(
    input  wire                   i_clk,
    input  wire                   i_flush,
    input  wire rv_pkg::mem_wb_t  i_op,
    input  wire [`RV_XLEN-1:0]    i_data,
    output rv_pkg::wb_t           o_wb
);

    import rv_pkg::*;

    mem_wb_t             op_q;
    logic [7:0]          ld_byte;
    logic [15:0]         ld_half;
    logic [`RV_XLEN-1:0] ld_value;
    logic [`RV_XLEN-1:0] wb_data;

    // flush cancels the operation being captured
    always_ff @(posedge i_clk)
    begin
        op_q <= i_op;
        if (i_flush)
        begin
            op_q.res_src   <= '0;
            op_q.reg_write <= 1'b0;
        end
    end

    always_comb
    begin
        case (op_q.alu_result[1:0])
        2'b00  : ld_byte = i_data[ 0 +: 8];
        2'b01  : ld_byte = i_data[ 8 +: 8];
        2'b10  : ld_byte = i_data[16 +: 8];
        default: ld_byte = i_data[24 +: 8];
        endcase
    end

    assign ld_half = op_q.alu_result[1] ? i_data[16 +: 16] : i_data[0 +: 16];

    always_comb
    begin
        case (op_q.funct3)
        LS_B   : ld_value = {{24{ld_byte[7]}}, ld_byte};
        LS_H   : ld_value = {{16{ld_half[15]}}, ld_half};
        LS_W   : ld_value = i_data;
        LS_BU  : ld_value = {24'd0, ld_byte};
        LS_HU  : ld_value = {16'd0, ld_half};
        default: ld_value = '0;
        endcase
    end

    // pc_next goes the same way as alu
    always_comb
    begin
        if (op_q.res_src.memory)
        begin
            wb_data = ld_value;
        end
        else
        begin
            wb_data = op_q.alu_result;
        end
    end

    assign o_wb = '{
        data:  wb_data,
        rd:    op_q.rd,
        write: op_q.reg_write
    };

    // selector stays one-hot once it has left reset
    a_res_src_onehot: assert property (@(posedge i_clk)
        !$isunknown(op_q.res_src) |-> $onehot0(op_q.res_src));

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
    output logic o_clk
);

    localparam realtime HALF_PERIOD = 5ns;     // 10 ns clock

    initial
    begin
        o_clk = 1'b0;
        forever
        begin
            #(HALF_PERIOD) o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_rv_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module tb_rv_mem_wb;

    import rv_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int N_ALU = 24;
    localparam int N_RANDOM = 300;
    localparam int READBACK_CYCLES = 35;
    localparam int EST_CYCLES = RESET_CYCLES + N_ALU + 8 + 7 * 14 + 7 + 4 + N_RANDOM
                              + 5 * READBACK_CYCLES;
    localparam int WATCHDOG_NS = 2 * EST_CYCLES * 10;
    localparam logic [31:0] BASE = 32'h0000_0100;  // 8 words used from here
    localparam int K_ALU = 0;
    localparam int K_PC = 1;
    localparam int K_LOAD = 2;
    localparam int K_STORE = 3;

    logic                  clk;
    logic                  reset;
    logic                  flush;
    ex_mem_t               op_in;
    logic [`RV_REG_AW-1:0] rs_addr;
    wb_t                   wb_out;
    logic [`RV_XLEN-1:0]   rs_data;

    // reference model state
    ex_mem_t               m_mem;
    ex_mem_t               m_wb;
    logic [31:0]           m_wb_word;
    logic [31:0]           m_ram [`RV_RAM_WORDS];
    logic [31:0]           m_regs [32];
    ex_mem_t               pend_op;
    logic                  pend_flush;

    logic [31:0]           lfsr = 32'd27;
    int                    test_checks;
    int                    test_errors;
    int                    total_checks;
    int                    total_errors;

    // aligned access tables of width and byte offset
    ls_width_t st_w [7] = '{LS_B, LS_B, LS_B, LS_B, LS_H, LS_H, LS_W};
    int        st_off [7] = '{0, 1, 2, 3, 0, 2, 0};
    ls_width_t ld_w [13] = '{LS_B, LS_B, LS_B, LS_B, LS_BU, LS_BU, LS_BU, LS_BU,
                             LS_H, LS_H, LS_HU, LS_HU, LS_W};
    int        ld_off [13] = '{0, 1, 2, 3, 0, 1, 2, 3, 0, 2, 0, 2, 0};

    tb_clock u_clock
    (
        .o_clk  (clk)
    );

    rv_mem_wb uut
    (
        .i_clk      (clk),
        .i_reset    (reset),
        .i_flush    (flush),
        .i_op       (op_in),
        .i_rs_addr  (rs_addr),
        .o_wb       (wb_out),
        .o_rs_data  (rs_data)
    );

    // galois lfsr for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [4:0] next_rd();
        logic [4:0] r;
        r = 5'(lfsr_bits(5));
        return (r == 5'd0) ? 5'd1 : r;
    endfunction

    function automatic ex_mem_t make_op(input int kind, input logic [31:0] a,
                                        input logic [31:0] d, input ls_width_t w,
                                        input logic [4:0] rd);
        ex_mem_t op;
        op = '0;
        op.alu_result = a;
        op.store_data = d;
        op.funct3 = w;
        op.rd = rd;
        op.res_src.alu = (kind == K_ALU);
        op.res_src.pc_next = (kind == K_PC);
        op.res_src.memory = (kind == K_LOAD);
        op.reg_write = (kind != K_STORE);
        op.mem_write = (kind == K_STORE);
        return op;
    endfunction

    // load value or alu result as seen at write-back
    function automatic logic [31:0] wb_value(input ex_mem_t op, input logic [31:0] word);
        logic [31:0] sh;
        sh = word >> (8 * op.alu_result[1:0]);
        if (!op.res_src.memory)
            return op.alu_result;
        case (op.funct3)
        LS_B   : return {{24{sh[7]}}, sh[7:0]};
        LS_H   : return {{16{sh[15]}}, sh[15:0]};
        LS_BU  : return {24'd0, sh[7:0]};
        LS_HU  : return {16'd0, sh[15:0]};
        default: return word;
        endcase
    endfunction

    // one model clock edge with the inputs the DUT sees at that edge
    task automatic model_edge(input ex_mem_t op, input logic fl);
        int widx;
        int lane;
        if (m_wb.reg_write && m_wb.rd != 5'd0)
            m_regs[m_wb.rd] = wb_value(m_wb, m_wb_word);
        widx = m_mem.alu_result[2 +: `RV_RAM_AW];
        lane = m_mem.alu_result[1:0];
        m_wb_word = m_ram[widx];                    // read before write
        m_wb = m_mem;
        if (m_mem.mem_write && !fl)
        begin
            case (m_mem.funct3)
            LS_B   : m_ram[widx][8 * lane +: 8] = m_mem.store_data[7:0];
            LS_H   : m_ram[widx][8 * lane +: 16] = m_mem.store_data[15:0];
            default: m_ram[widx] = m_mem.store_data;
            endcase
        end
        m_mem = op;
        if (fl)
        begin
            m_wb.res_src = '0;
            m_wb.reg_write = 1'b0;
            m_mem.res_src = '0;
            m_mem.reg_write = 1'b0;
            m_mem.mem_write = 1'b0;
        end
    endtask

    task automatic run_cycle(input ex_mem_t op, input logic fl = 1'b0,
                             input logic [4:0] rs = '0, input logic check_rs = 1'b0);
        logic [31:0] exp_data;
        @(posedge clk);
        model_edge(pend_op, pend_flush);
        op_in <= op;
        flush <= fl;
        rs_addr <= rs;
        pend_op = op;
        pend_flush = fl;
        @(negedge clk);
        exp_data = wb_value(m_wb, m_wb_word);
        test_checks++;
        assert (wb_out.write === m_wb.reg_write && (!m_wb.reg_write ||
                (wb_out.rd === m_wb.rd && wb_out.data === exp_data)))
        else
        begin
            test_errors++;
            $display("Mismatch at %0t ns: o_wb write %b rd %0d data %h, expected %b %0d %h",
                     $time, wb_out.write, wb_out.rd, wb_out.data,
                     m_wb.reg_write, m_wb.rd, exp_data);
        end
        if (check_rs)
        begin
            test_checks++;
            assert (rs_data === m_regs[rs])
            else
            begin
                test_errors++;
                $display("Mismatch at %0t ns: x%0d reads %h, expected %h",
                         $time, rs, rs_data, m_regs[rs]);
            end
        end
    endtask

    task automatic read_back_regs();
        repeat (3) run_cycle('0);                   // drain pipeline
        for (int r = 0; r < 32; r++)
            run_cycle('0, 1'b0, 5'(r), 1'b1);
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d checks, %0d errors", num, name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        int          kind;
        int          idx;
        logic [31:0] value;
        logic [4:0]  rd;
        reset = 1'b1;
        flush = 1'b0;
        op_in = '0;
        rs_addr = '0;
        m_mem = '0;
        m_wb = '0;
        pend_op = '0;
        pend_flush = 1'b0;
        for (int r = 0; r < 32; r++)
            m_regs[r] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        for (int n = 0; n < N_ALU; n++)
        begin
            kind = lfsr_bits(1);                    // alu or pc_next
            value = lfsr_bits(32);
            rd = next_rd();
            run_cycle(make_op(kind, value, '0, LS_W, rd));
        end
        read_back_regs();
        report_test(1, "alu and pc_next results");

        for (int k = 0; k < 8; k++)
            run_cycle(make_op(K_STORE, BASE + 4 * k, lfsr_bits(32), LS_W, '0));
        for (int s = 0; s < 7; s++)
        begin
            value = lfsr_bits(32);
            run_cycle(make_op(K_STORE, BASE + 4 * s + st_off[s], value, st_w[s], '0));
            for (int l = 0; l < 13; l++)
            begin
                rd = next_rd();
                run_cycle(make_op(K_LOAD, BASE + 4 * s + ld_off[l], '0, ld_w[l], rd));
            end
        end
        read_back_regs();
        report_test(2, "store lanes and load extension");

        run_cycle(make_op(K_ALU, 32'h1234_5678, '0, LS_W, 5'd7));     // survives
        run_cycle(make_op(K_ALU, 32'hdead_beef, '0, LS_W, 5'd7));
        run_cycle(make_op(K_STORE, BASE, 32'hffff_ffff, LS_W, '0), 1'b1);
        run_cycle(make_op(K_STORE, BASE + 4, 32'h0, LS_W, '0));
        run_cycle(make_op(K_LOAD, BASE + 4, '0, LS_W, 5'd8), 1'b1);
        run_cycle(make_op(K_LOAD, BASE, '0, LS_W, 5'd9));
        run_cycle(make_op(K_LOAD, BASE + 4, '0, LS_W, 5'd10));
        read_back_regs();
        report_test(3, "flush of operations in flight");

        run_cycle(make_op(K_ALU, lfsr_bits(32), '0, LS_W, 5'd0));
        run_cycle(make_op(K_PC, lfsr_bits(32), '0, LS_W, 5'd0));
        run_cycle(make_op(K_LOAD, BASE + 8, '0, LS_W, 5'd0));
        run_cycle(make_op(K_ALU, 32'hffff_ffff, '0, LS_W, 5'd0));
        read_back_regs();
        report_test(4, "writes to register zero");

        for (int n = 0; n < N_RANDOM; n++)
        begin
            kind = lfsr_bits(2);
            rd = 5'(lfsr_bits(5));
            value = BASE + 4 * lfsr_bits(3);
            if (kind == K_LOAD)
            begin
                idx = lfsr_bits(4) % 13;
                run_cycle(make_op(kind, value + ld_off[idx], '0, ld_w[idx], rd));
            end
            else if (kind == K_STORE)
            begin
                idx = lfsr_bits(3) % 7;
                run_cycle(make_op(kind, value + st_off[idx], lfsr_bits(32), st_w[idx], rd));
            end
            else
            begin
                run_cycle(make_op(kind, lfsr_bits(32), '0, LS_W, rd));
            end
        end
        read_back_regs();
        report_test(5, "random back-to-back mix");

        $display("all tests: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
